// ==== source/lsu_pkg.sv ====
package lsu_pkg;

    localparam int NUM_LANES = 4;
    localparam int WORD_W = 32;
    localparam int WID_W = 2;
    localparam int RD_W = 5;
    localparam int ALIGN_W = 2;
    localparam int LANE_W = $clog2(NUM_LANES);

    typedef enum logic [2:0] {
        LSU_LB  = 3'd0,
        LSU_LH  = 3'd1,
        LSU_LW  = 3'd2,
        LSU_LBU = 3'd3,
        LSU_LHU = 3'd4,
        LSU_SB  = 3'd5,
        LSU_SH  = 3'd6,
        LSU_SW  = 3'd7
    } lsu_op_e;

    typedef enum logic [1:0] {
        SCHED_IDLE   = 2'd0,
        SCHED_SETUP  = 2'd1,
        SCHED_ACCESS = 2'd2,
        SCHED_DONE   = 2'd3
    } sched_state_e;

    typedef logic [NUM_LANES-1:0][WORD_W-1:0]  lane_word_t;
    typedef logic [NUM_LANES-1:0][3:0]         lane_strb_t;
    typedef logic [NUM_LANES-1:0][ALIGN_W-1:0] lane_align_t;
    typedef logic [NUM_LANES-1:0]              lane_mask_t;

    function automatic logic op_is_store(lsu_op_e op);
        return (op == LSU_SB) || (op == LSU_SH) || (op == LSU_SW);
    endfunction

    // 0 byte, 1 halfword, 2 word
    function automatic logic [1:0] op_size(lsu_op_e op);
        logic [1:0] size;
        case (op)
            LSU_LB, LSU_LBU, LSU_SB: size = 2'd0;
            LSU_LH, LSU_LHU, LSU_SH: size = 2'd1;
            default:                 size = 2'd2;
        endcase
        return size;
    endfunction

endpackage

// ==== source/lsu_addr_gen.sv ====
`timescale 1ns/100ps

module lsu_addr_gen
    import lsu_pkg::*;
(
    input  lsu_op_e           req_op,
    input  lane_mask_t        req_tmask,
    input  lane_word_t        req_base_addr,
    input  logic [WORD_W-1:0] req_offset,
    input  lane_word_t        req_store_data,
    output lane_word_t        lane_addr,
    output lane_align_t       lane_align,
    output lane_strb_t        lane_strb,
    output lane_word_t        lane_wdata,
    output lane_mask_t        issue_mask,
    output logic              is_dup
);

    lane_word_t full_addr;
    lane_mask_t base_match;
    logic       is_store;

    assign is_store = op_is_store(req_op);

    // inactive lanes never break a duplicate
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            base_match[i] = (req_base_addr[i] == req_base_addr[0]) || !req_tmask[i];
        end
    end

    assign is_dup = req_tmask[0] && (&base_match);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign full_addr[i]  = req_base_addr[i] + req_offset;
        assign lane_addr[i]  = {full_addr[i][WORD_W-1:ALIGN_W], {ALIGN_W{1'b0}}};
        assign lane_align[i] = full_addr[i][ALIGN_W-1:0];
        assign issue_mask[i] = req_tmask[i] && (!is_dup || (i == 0));
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_wdata[i] = req_store_data[i] << {lane_align[i], 3'b000};
            if (!is_store) begin
                lane_strb[i] = 4'hf;
            end else begin
                case (op_size(req_op))
                    2'd0: begin
                        lane_strb[i] = 4'b0001 << lane_align[i];
                    end
                    2'd1: begin
                        // halfword lands in the low or high half
                        lane_strb[i] = lane_align[i][1] ? 4'b1100 : 4'b0011;
                    end
                    default: begin
                        lane_strb[i] = 4'hf;
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/lsu_lane_sched.sv ====
`timescale 1ns/100ps

module lsu_lane_sched
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  lsu_op_e           req_op,
    input  logic [WID_W-1:0]  req_wid,
    input  logic [WORD_W-1:0] req_pc,
    input  logic [RD_W-1:0]   req_rd,
    input  lane_mask_t        req_tmask,
    input  lane_word_t        lane_addr,
    input  lane_align_t       lane_align,
    input  lane_strb_t        lane_strb,
    input  lane_word_t        lane_wdata,
    input  lane_mask_t        issue_mask,
    input  logic              is_dup,
    input  logic [WORD_W-1:0] prdata,
    input  logic              pready,
    input  logic              rsp_ready,
    output logic              req_ready,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output logic [WORD_W-1:0] paddr,
    output logic [WORD_W-1:0] pwdata,
    output logic [3:0]        pstrb,
    output logic              rsp_valid,
    output lsu_op_e           rsp_op,
    output logic [WID_W-1:0]  rsp_wid,
    output logic [WORD_W-1:0] rsp_pc,
    output logic [RD_W-1:0]   rsp_rd,
    output lane_mask_t        rsp_tmask,
    output lane_align_t       rsp_align,
    output logic              rsp_is_dup,
    output lane_word_t        rsp_rdata
);

    sched_state_e      state;
    lane_mask_t        pending;
    lane_mask_t        pending_next;
    logic [LANE_W-1:0] cur_lane;
    lane_word_t        lat_addr;
    lane_word_t        lat_wdata;
    lane_strb_t        lat_strb;

    // lowest pending lane wins
    always_comb begin
        cur_lane = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                cur_lane = LANE_W'(i);
            end
        end
    end

    assign pending_next = pending & ~(lane_mask_t'(1) << cur_lane);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= SCHED_IDLE;
            pending <= '0;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (req_valid) begin
                        pending <= issue_mask;
                        if (issue_mask != '0) begin
                            state <= SCHED_SETUP;
                        end else if (!op_is_store(req_op)) begin
                            state <= SCHED_DONE;
                        end
                    end
                end
                SCHED_SETUP: begin
                    state <= SCHED_ACCESS;
                end
                SCHED_ACCESS: begin
                    if (pready) begin
                        pending <= pending_next;
                        if (pending_next != '0) begin
                            state <= SCHED_SETUP;
                        end else if (pwrite) begin
                            state <= SCHED_IDLE;
                        end else begin
                            state <= SCHED_DONE;
                        end
                    end
                end
                default: begin
                    if (rsp_ready) begin
                        state <= SCHED_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            rsp_op     <= req_op;
            rsp_wid    <= req_wid;
            rsp_pc     <= req_pc;
            rsp_rd     <= req_rd;
            rsp_tmask  <= req_tmask;
            rsp_align  <= lane_align;
            rsp_is_dup <= is_dup;
            lat_addr   <= lane_addr;
            lat_wdata  <= lane_wdata;
            lat_strb   <= lane_strb;
        end
        if ((state == SCHED_ACCESS) && pready && !pwrite) begin
            rsp_rdata[cur_lane] <= prdata;
        end
    end

    assign req_ready = (state == SCHED_IDLE);
    assign rsp_valid = (state == SCHED_DONE);

    assign psel    = (state == SCHED_SETUP) || (state == SCHED_ACCESS);
    assign penable = (state == SCHED_ACCESS);
    assign pwrite  = op_is_store(rsp_op);
    assign paddr   = lat_addr[cur_lane];
    assign pwdata  = lat_wdata[cur_lane];
    assign pstrb   = lat_strb[cur_lane];

endmodule

// ==== source/lsu_load_format.sv ====
`timescale 1ns/100ps

module lsu_load_format
    import lsu_pkg::*;
(
    input  lsu_op_e     rsp_op,
    input  lane_align_t rsp_align,
    input  logic        rsp_is_dup,
    input  lane_word_t  rsp_rdata,
    output lane_word_t  ld_data
);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [WORD_W-1:0] word;
        logic [15:0]       half;
        logic [7:0]        byte_val;
        logic [WORD_W-1:0] ext;

        // duplicate requests only fetched lane 0
        assign word     = rsp_is_dup ? rsp_rdata[0] : rsp_rdata[i];
        assign half     = rsp_align[i][1] ? word[31:16] : word[15:0];
        assign byte_val = rsp_align[i][0] ? half[15:8] : half[7:0];

        always_comb begin
            case (rsp_op)
                LSU_LB: begin
                    ext = {{(WORD_W-8){byte_val[7]}}, byte_val};
                end
                LSU_LH: begin
                    ext = {{(WORD_W-16){half[15]}}, half};
                end
                LSU_LBU: begin
                    ext = {{(WORD_W-8){1'b0}}, byte_val};
                end
                LSU_LHU: begin
                    ext = {{(WORD_W-16){1'b0}}, half};
                end
                default: begin
                    ext = word;
                end
            endcase
        end

        assign ld_data[i] = ext;
    end

endmodule

// ==== source/lsu_commit_buf.sv ====
`timescale 1ns/100ps

module lsu_commit_buf
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  logic [WID_W-1:0]  in_wid,
    input  logic [WORD_W-1:0] in_pc,
    input  logic [RD_W-1:0]   in_rd,
    input  lane_mask_t        in_tmask,
    input  lane_word_t        in_data,
    output logic              in_ready,
    output logic              out_valid,
    output logic [WID_W-1:0]  out_wid,
    output logic [WORD_W-1:0] out_pc,
    output logic [RD_W-1:0]   out_rd,
    output lane_mask_t        out_tmask,
    output lane_word_t        out_data,
    input  logic              out_ready
);

    logic [WID_W-1:0]  skid_wid;
    logic [WORD_W-1:0] skid_pc;
    logic [RD_W-1:0]   skid_rd;
    lane_mask_t        skid_tmask;
    lane_word_t        skid_data;
    logic              out_load;

    // main register free or draining this cycle
    assign out_load = out_ready || !out_valid;

    // in_ready low means the side register holds an entry
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end else if (out_load) begin
            out_valid <= !in_ready || in_valid;
            in_ready  <= 1'b1;
        end else if (in_valid && in_ready) begin
            in_ready <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_wid   <= in_ready ? in_wid : skid_wid;
            out_pc    <= in_ready ? in_pc : skid_pc;
            out_rd    <= in_ready ? in_rd : skid_rd;
            out_tmask <= in_ready ? in_tmask : skid_tmask;
            out_data  <= in_ready ? in_data : skid_data;
        end else if (in_valid && in_ready) begin
            skid_wid   <= in_wid;
            skid_pc    <= in_pc;
            skid_rd    <= in_rd;
            skid_tmask <= in_tmask;
            skid_data  <= in_data;
        end
    end

endmodule

// ==== source/lsu_unit.sv ====
`timescale 1ns/100ps

module lsu_unit
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  lsu_op_e           req_op,
    input  logic [WID_W-1:0]  req_wid,
    input  logic [WORD_W-1:0] req_pc,
    input  logic [RD_W-1:0]   req_rd,
    input  lane_mask_t        req_tmask,
    input  lane_word_t        req_base_addr,
    input  logic [WORD_W-1:0] req_offset,
    input  lane_word_t        req_store_data,
    output logic              req_ready,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output logic [WORD_W-1:0] paddr,
    output logic [WORD_W-1:0] pwdata,
    output logic [3:0]        pstrb,
    input  logic [WORD_W-1:0] prdata,
    input  logic              pready,
    output logic              st_commit_valid,
    output logic [WID_W-1:0]  st_commit_wid,
    output logic [WORD_W-1:0] st_commit_pc,
    output lane_mask_t        st_commit_tmask,
    output logic              ld_commit_valid,
    output logic [WID_W-1:0]  ld_commit_wid,
    output logic [WORD_W-1:0] ld_commit_pc,
    output logic [RD_W-1:0]   ld_commit_rd,
    output lane_mask_t        ld_commit_tmask,
    output lane_word_t        ld_commit_data,
    input  logic              ld_commit_ready
);

    lane_word_t        lane_addr;
    lane_align_t       lane_align;
    lane_strb_t        lane_strb;
    lane_word_t        lane_wdata;
    lane_mask_t        issue_mask;
    logic              is_dup;
    logic              rsp_valid;
    logic              rsp_ready;
    lsu_op_e           rsp_op;
    logic [WID_W-1:0]  rsp_wid;
    logic [WORD_W-1:0] rsp_pc;
    logic [RD_W-1:0]   rsp_rd;
    lane_mask_t        rsp_tmask;
    lane_align_t       rsp_align;
    logic              rsp_is_dup;
    lane_word_t        rsp_rdata;
    lane_word_t        ld_data;

    lsu_addr_gen addr_gen_inst (
        .req_op         (req_op),
        .req_tmask      (req_tmask),
        .req_base_addr  (req_base_addr),
        .req_offset     (req_offset),
        .req_store_data (req_store_data),
        .lane_addr      (lane_addr),
        .lane_align     (lane_align),
        .lane_strb      (lane_strb),
        .lane_wdata     (lane_wdata),
        .issue_mask     (issue_mask),
        .is_dup         (is_dup)
    );

    lsu_lane_sched lane_sched_inst (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_wid    (req_wid),
        .req_pc     (req_pc),
        .req_rd     (req_rd),
        .req_tmask  (req_tmask),
        .lane_addr  (lane_addr),
        .lane_align (lane_align),
        .lane_strb  (lane_strb),
        .lane_wdata (lane_wdata),
        .issue_mask (issue_mask),
        .is_dup     (is_dup),
        .prdata     (prdata),
        .pready     (pready),
        .rsp_ready  (rsp_ready),
        .req_ready  (req_ready),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .rsp_valid  (rsp_valid),
        .rsp_op     (rsp_op),
        .rsp_wid    (rsp_wid),
        .rsp_pc     (rsp_pc),
        .rsp_rd     (rsp_rd),
        .rsp_tmask  (rsp_tmask),
        .rsp_align  (rsp_align),
        .rsp_is_dup (rsp_is_dup),
        .rsp_rdata  (rsp_rdata)
    );

    lsu_load_format load_format_inst (
        .rsp_op     (rsp_op),
        .rsp_align  (rsp_align),
        .rsp_is_dup (rsp_is_dup),
        .rsp_rdata  (rsp_rdata),
        .ld_data    (ld_data)
    );

    lsu_commit_buf commit_buf_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rsp_valid),
        .in_wid    (rsp_wid),
        .in_pc     (rsp_pc),
        .in_rd     (rsp_rd),
        .in_tmask  (rsp_tmask),
        .in_data   (ld_data),
        .in_ready  (rsp_ready),
        .out_valid (ld_commit_valid),
        .out_wid   (ld_commit_wid),
        .out_pc    (ld_commit_pc),
        .out_rd    (ld_commit_rd),
        .out_tmask (ld_commit_tmask),
        .out_data  (ld_commit_data),
        .out_ready (ld_commit_ready)
    );

    // stores retire at acceptance
    assign st_commit_valid = req_valid && req_ready && op_is_store(req_op);
    assign st_commit_wid   = req_wid;
    assign st_commit_pc    = req_pc;
    assign st_commit_tmask = req_tmask;

endmodule

// ==== test/apb_mem_model.sv ====
`timescale 1ns/100ps

module apb_mem_model
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [WORD_W-1:0] paddr,
    input  logic [WORD_W-1:0] pwdata,
    input  logic [3:0]        pstrb,
    output logic [WORD_W-1:0] prdata,
    output logic              pready,
    output int unsigned       xfer_count
);

    // 64 words indexed by paddr[7:2]
    logic [WORD_W-1:0] mem [64];
    logic [1:0]        wait_cnt;
    logic [5:0]        index;

    assign index  = paddr[7:2];
    assign prdata = mem[index];
    assign pready = psel && penable && (wait_cnt == 2'd0);

    // fill value depends on every index bit
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = (i + 1) * 32'h9e37_79b1;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            wait_cnt   <= 2'd0;
            xfer_count <= 0;
        end else if (psel && !penable) begin
            wait_cnt <= 2'($urandom_range(3, 0));
        end else if (psel && penable) begin
            if (pready) begin
                xfer_count <= xfer_count + 1;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (psel && penable && pready && pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    mem[index][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== test/tb_lsu_unit.sv ====
`timescale 1ns/100ps

module tb_lsu_unit
    import lsu_pkg::*;
();

    localparam int REQ_COUNT = 21;
    localparam int CLK_PERIOD = 4;

    logic              clk;
    logic              reset;
    logic              req_valid;
    lsu_op_e           req_op;
    logic [WID_W-1:0]  req_wid;
    logic [WORD_W-1:0] req_pc;
    logic [RD_W-1:0]   req_rd;
    lane_mask_t        req_tmask;
    lane_word_t        req_base_addr;
    logic [WORD_W-1:0] req_offset;
    lane_word_t        req_store_data;
    logic              req_ready;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [WORD_W-1:0] paddr;
    logic [WORD_W-1:0] pwdata;
    logic [3:0]        pstrb;
    logic [WORD_W-1:0] prdata;
    logic              pready;
    logic              st_commit_valid;
    logic [WID_W-1:0]  st_commit_wid;
    logic [WORD_W-1:0] st_commit_pc;
    lane_mask_t        st_commit_tmask;
    logic              ld_commit_valid;
    logic [WID_W-1:0]  ld_commit_wid;
    logic [WORD_W-1:0] ld_commit_pc;
    logic [RD_W-1:0]   ld_commit_rd;
    lane_mask_t        ld_commit_tmask;
    lane_word_t        ld_commit_data;
    logic              ld_commit_ready;
    int unsigned       xfer_count;

    int error_count = 0;
    int test_start_errors = 0;
    int pass_count = 0;
    int fail_count = 0;

    // scoreboard copy of the model memory
    logic [31:0]      ref_mem [64];
    logic [31:0]      exp_paddr [$];
    logic             exp_pwrite [$];
    logic [3:0]       exp_pstrb [$];
    logic [31:0]      exp_pwdata [$];
    logic [WID_W-1:0] exp_wid [$];
    logic [31:0]      exp_pc [$];
    logic [RD_W-1:0]  exp_rd [$];
    lane_mask_t       exp_tmask [$];
    lane_word_t       exp_data [$];

    lsu_unit lsu_unit_inst (.*);

    apb_mem_model mem_model_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    apb_hold: assert property (@(posedge clk) disable iff (reset)
        psel && !(penable && pready) |=> psel && penable && $stable(paddr)
            && $stable(pwrite) && $stable(pwdata) && $stable(pstrb))
    else begin
        $display("APB transfer changed or dropped before pready at %0t", $time);
        error_count++;
    end

    // every transfer opens with a setup cycle
    apb_setup: assert property (@(posedge clk) disable iff (reset)
        (!psel || (penable && pready)) |=> !penable)
    else begin
        $display("APB access phase started without a setup cycle at %0t", $time);
        error_count++;
    end

    apb_align: assert property (@(posedge clk) disable iff (reset)
        psel |-> paddr[1:0] == 2'b00)
    else begin
        $display("** Error: paddr[1:0] expected %h, got %h", 2'b00, paddr[1:0]);
        error_count++;
    end

    st_commit_once: assert property (@(posedge clk) disable iff (reset)
        st_commit_valid |-> req_valid && req_ready)
    else begin
        $display("st_commit_valid raised outside a store acceptance at %0t", $time);
        error_count++;
    end

    ld_hold: assert property (@(posedge clk) disable iff (reset)
        ld_commit_valid && !ld_commit_ready |=> ld_commit_valid && $stable(ld_commit_data)
            && $stable(ld_commit_wid) && $stable(ld_commit_pc) && $stable(ld_commit_rd)
            && $stable(ld_commit_tmask))
    else begin
        $display("load commit changed while ld_commit_ready was low at %0t", $time);
        error_count++;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error: %s expected %h, got %h", name, expected, actual);
            error_count++;
        end
    endtask

    function automatic logic [31:0] format_load(lsu_op_e op, logic [31:0] word,
                                                logic [1:0] align);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*align +: 8];
        h = word[16*align[1] +: 16];
        case (op)
            LSU_LB:  return {{24{b[7]}}, b};
            LSU_LBU: return {24'h0, b};
            LSU_LH:  return {{16{h[15]}}, h};
            LSU_LHU: return {16'h0, h};
            default: return word;
        endcase
    endfunction

    function automatic lane_word_t random_words();
        lane_word_t words;
        for (int i = 0; i < NUM_LANES; i++) begin
            words[i] = $urandom;
        end
        return words;
    endfunction

    // four distinct model words with byte offsets limited by align_mask
    task automatic pick_bases(output lane_word_t base, input logic [1:0] align_mask);
        logic [5:0] start;
        start = 6'($urandom);
        for (int i = 0; i < NUM_LANES; i++) begin
            base[i]      = $urandom;
            base[i][7:2] = start + 6'(i * 16);
            base[i][1:0] = 2'($urandom) & align_mask;
        end
    endtask

    task automatic send_req(input lsu_op_e op, input lane_mask_t tmask, input lane_word_t base,
                            input logic [31:0] offset, input lane_word_t data);
        logic [WID_W-1:0] wid;
        logic [31:0]      pc;
        logic [RD_W-1:0]  rd;
        logic             store;
        logic             dup;
        logic [31:0]      addr;
        logic [31:0]      src_addr;
        logic [3:0]       strb;
        logic [31:0]      wdata;
        lane_word_t       ld_words;
        wid   = WID_W'($urandom);
        pc    = $urandom & 32'hffff_fffc;
        rd    = RD_W'($urandom);
        store = (op == LSU_SB) || (op == LSU_SH) || (op == LSU_SW);
        @(posedge clk);
        req_valid      <= 1'b1;
        req_op         <= op;
        req_wid        <= wid;
        req_pc         <= pc;
        req_rd         <= rd;
        req_tmask      <= tmask;
        req_base_addr  <= base;
        req_offset     <= offset;
        req_store_data <= data;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
        check_value("st_commit_valid", store, st_commit_valid);
        if (store) begin
            check_value("st_commit_wid", wid, st_commit_wid);
            check_value("st_commit_pc", pc, st_commit_pc);
            check_value("st_commit_tmask", tmask, st_commit_tmask);
        end
        dup = tmask[0];
        for (int i = 1; i < NUM_LANES; i++) begin
            if (tmask[i] && (base[i] != base[0])) begin
                dup = 1'b0;
            end
        end
        // expected APB transfers in lowest-lane-first order
        for (int i = 0; i < NUM_LANES; i++) begin
            addr = base[i] + offset;
            if (tmask[i] && (!dup || (i == 0))) begin
                strb = 4'hf;
                if (op == LSU_SB) begin
                    strb = 4'b0001 << addr[1:0];
                end else if (op == LSU_SH) begin
                    strb = 4'b0011 << {addr[1], 1'b0};
                end
                wdata = data[i] << (8 * addr[1:0]);
                exp_paddr.push_back({addr[31:2], 2'b00});
                exp_pwrite.push_back(store);
                exp_pstrb.push_back(strb);
                exp_pwdata.push_back(wdata);
                for (int b = 0; b < 4; b++) begin
                    if (store && strb[b]) begin
                        ref_mem[addr[7:2]][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
            end
        end
        if (!store) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                addr        = base[i] + offset;
                src_addr    = base[dup ? 0 : i] + offset;
                ld_words[i] = format_load(op, ref_mem[src_addr[7:2]], addr[1:0]);
            end
            exp_wid.push_back(wid);
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_tmask.push_back(tmask);
            exp_data.push_back(ld_words);
        end
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
        end while (!req_ready || (exp_wid.size() != 0) || (exp_paddr.size() != 0));
    endtask

    task automatic counted_req(input lsu_op_e op, input lane_mask_t tmask,
                               input lane_word_t base, input int unsigned transfers);
        int unsigned start;
        start = xfer_count;
        send_req(op, tmask, base, 32'h0, random_words());
        wait_drain();
        check_value("xfer_count step", transfers, xfer_count - start);
    endtask

    task automatic end_test(input string name);
        wait_drain();
        if (error_count == test_start_errors) begin
            $display("test %s: passed", name);
            pass_count++;
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - test_start_errors);
            fail_count++;
        end
        test_start_errors = error_count;
    endtask

    always @(posedge clk) begin : apb_monitor
        logic        write;
        logic [31:0] wdata;
        if (!reset && psel && penable && pready) begin
            if (exp_paddr.size() == 0) begin
                $display("unexpected APB transfer to address %h", paddr);
                error_count++;
            end else begin
                check_value("paddr", exp_paddr.pop_front(), paddr);
                write = exp_pwrite.pop_front();
                check_value("pwrite", write, pwrite);
                check_value("pstrb", exp_pstrb.pop_front(), pstrb);
                wdata = exp_pwdata.pop_front();
                if (write) begin
                    check_value("pwdata", wdata, pwdata);
                end
            end
        end
    end

    always @(posedge clk) begin : load_monitor
        lane_mask_t tmask;
        lane_word_t data;
        if (!reset && ld_commit_valid && ld_commit_ready) begin
            if (exp_wid.size() == 0) begin
                $display("load result arrived with no load outstanding");
                error_count++;
            end else begin
                check_value("ld_commit_wid", exp_wid.pop_front(), ld_commit_wid);
                check_value("ld_commit_pc", exp_pc.pop_front(), ld_commit_pc);
                check_value("ld_commit_rd", exp_rd.pop_front(), ld_commit_rd);
                tmask = exp_tmask.pop_front();
                data  = exp_data.pop_front();
                check_value("ld_commit_tmask", tmask, ld_commit_tmask);
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (tmask[i]) begin
                        check_value($sformatf("ld_commit_data[%0d]", i), data[i],
                                    ld_commit_data[i]);
                    end
                end
            end
        end
    end

    initial begin
        #(REQ_COUNT * NUM_LANES * 5 * CLK_PERIOD * 4);
        $display("watchdog expired at %0t with requests still outstanding", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        lane_word_t  base;
        lane_word_t  data;
        logic [31:0] offset;
        logic [31:0] b;
        int unsigned start;
        void'($urandom(32'hb1f7));
        reset           = 1'b1;
        req_valid       = 1'b0;
        req_op          = LSU_LW;
        req_wid         = '0;
        req_pc          = '0;
        req_rd          = '0;
        req_tmask       = '0;
        req_base_addr   = '0;
        req_offset      = '0;
        req_store_data  = '0;
        ld_commit_ready = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = mem_model_inst.mem[i];
        end

        check_value("psel", 0, psel);
        check_value("penable", 0, penable);
        check_value("st_commit_valid", 0, st_commit_valid);
        check_value("ld_commit_valid", 0, ld_commit_valid);
        check_value("req_ready", 1, req_ready);
        end_test("reset_idle");

        pick_bases(base, 2'b00);
        offset = 32'($urandom_range(0, 15)) << 2;
        data   = random_words();
        send_req(LSU_SW, 4'hf, base, offset, data);
        send_req(LSU_LW, 4'hf, base, offset, data);
        end_test("word_traffic");

        for (int round = 0; round < 2; round++) begin
            pick_bases(base, 2'b11);
            offset     = 32'($urandom_range(0, 15)) << 2;
            data       = random_words();
            // negative bytes on two lanes
            data[0][7] = 1'b1;
            data[2][7] = 1'b1;
            send_req(LSU_SB, 4'hf, base, offset, data);
            send_req(LSU_LB, 4'hf, base, offset, data);
            send_req(LSU_LBU, 4'hf, base, offset, data);
            pick_bases(base, 2'b10);
            data        = random_words();
            data[1][15] = 1'b1;
            data[3][15] = 1'b1;
            send_req(LSU_SH, 4'hf, base, offset, data);
            send_req(LSU_LH, 4'hf, base, offset, data);
            send_req(LSU_LHU, 4'hf, base, offset, data);
        end
        end_test("subword_access");

        b    = $urandom & 32'hffff_fffc;
        base = {4{b}};
        counted_req(LSU_SW, 4'hf, base, 1);
        counted_req(LSU_LW, 4'hf, base, 1);
        pick_bases(base, 2'b00);
        counted_req(LSU_LW, 4'b1010, base, 2);
        // lanes 1 and 3 differ but are inactive
        base[2] = base[0];
        counted_req(LSU_LW, 4'b0101, base, 1);
        end_test("dup_and_mask");

        @(posedge clk);
        ld_commit_ready <= 1'b0;
        start = xfer_count;
        for (int n = 0; n < 3; n++) begin
            pick_bases(base, 2'b00);
            send_req(LSU_LW, 4'hf, base, 32'h0, random_words());
        end
        while (xfer_count != start + 12) begin
            @(posedge clk);
        end
        @(posedge clk);
        check_value("req_ready", 0, req_ready);
        check_value("ld_commit_valid", 1, ld_commit_valid);
        ld_commit_ready <= 1'b1;
        end_test("back_pressure");

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if ((fail_count == 0) && (error_count == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
source/lsu_pkg.sv
source/lsu_addr_gen.sv
source/lsu_lane_sched.sv
source/lsu_load_format.sv
source/lsu_commit_buf.sv
source/lsu_unit.sv
test/apb_mem_model.sv
test/tb_lsu_unit.sv

// ==== Bender.yml ====
package:
  name: lsu_unit

sources:
  - files:
      - source/lsu_pkg.sv
      - source/lsu_addr_gen.sv
      - source/lsu_lane_sched.sv
      - source/lsu_load_format.sv
      - source/lsu_commit_buf.sv
      - source/lsu_unit.sv
  - target: test
    files:
      - test/apb_mem_model.sv
      - test/tb_lsu_unit.sv
